//--- logic/cp0_reg_pkg.sv
`default_nettype none

package cp0_reg_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  cp0_addr_t;

    // CP0 register numbers
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    typedef struct packed {
        logic [8:0] rsvd_31_23;
        logic       bev;
        logic [5:0] rsvd_21_16;
        logic [7:0] im;
        logic [5:0] rsvd_7_2;
        logic       exl;
        logic       ie;
    } cp0_status_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [13:0] rsvd_29_16;
        logic [7:0]  ip;
        logic        rsvd_7;
        logic [4:0]  exc_code;
        logic [1:0]  rsvd_1_0;
    } cp0_cause_t;

endpackage

`default_nettype wire

//--- logic/exc_pkg.sv
`default_nettype none

package exc_pkg;
    import cp0_reg_pkg::*;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_SYS  = 5'd8;
    localparam exc_code_t EXC_BP   = 5'd9;
    localparam exc_code_t EXC_RI   = 5'd10;
    localparam exc_code_t EXC_OV   = 5'd12;

    // One instruction leaving the commit stage
    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  slot;
        word_t data_addr;
        logic  adel_if;
        logic  ri;
        logic  ov;
        logic  sys;
        logic  bp;
        logic  adel;
        logic  ades;
        logic  eret;
    } exc_req_t;

    typedef struct packed {
        logic      taken;
        exc_code_t code;
        word_t     epc_value;
        logic      bd;
        word_t     bad_vaddr;
        logic      bad_vaddr_we;
    } exc_event_t;

endpackage

`default_nettype wire

//--- logic/cp0_timer.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_timer import cp0_reg_pkg::*; #(
    parameter int COUNT_DIV = 2
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  count_we,
    input  wire logic  compare_we,
    input  wire word_t wdata,
    output word_t      count,
    output word_t      compare,
    output logic       ti
);

    localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(COUNT_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    // Free-running divider, wraps every COUNT_DIV cycles
    assign tick = (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count_we) begin
            count <= wdata;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '0;
        end else if (compare_we) begin
            compare <= wdata;
        end
    end

    // Sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (compare_we) begin
            ti <= 1'b0;
        end else if (count == compare) begin
            ti <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/exc_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exc_unit import cp0_reg_pkg::*, exc_pkg::*; #(
    parameter word_t EXC_VECTOR = 32'hbfc00380
) (
    input  wire exc_req_t    req,
    input  wire cp0_status_t status,
    input  wire cp0_cause_t  cause,
    input  wire word_t       epc,
    output exc_event_t       exc_event,
    output logic             eret_go,
    output logic             flush,
    output word_t            flush_target
);

    logic int_pending;
    logic any_exc;

    assign int_pending = (|(cause.ip & status.im)) && status.ie && !status.exl;

    assign any_exc = req.adel_if | req.ri | req.ov | req.sys |
                     req.bp | req.adel | req.ades;

    always_comb begin
        exc_event       = '0;
        exc_event.taken = req.valid && (int_pending || any_exc);

        // Interrupt first, then fetch error down to store address error
        if (int_pending) begin
            exc_event.code = EXC_INT;
        end else if (req.adel_if) begin
            exc_event.code = EXC_ADEL;
        end else if (req.ri) begin
            exc_event.code = EXC_RI;
        end else if (req.ov) begin
            exc_event.code = EXC_OV;
        end else if (req.sys) begin
            exc_event.code = EXC_SYS;
        end else if (req.bp) begin
            exc_event.code = EXC_BP;
        end else if (req.adel) begin
            exc_event.code = EXC_ADEL;
        end else begin
            exc_event.code = EXC_ADES;
        end

        // Delay slot points back at the branch, except on a bad fetch
        if (req.slot && !req.adel_if) begin
            exc_event.epc_value = req.pc - 32'd4;
        end else begin
            exc_event.epc_value = req.pc;
        end

        exc_event.bd           = req.slot;
        exc_event.bad_vaddr    = req.adel_if ? req.pc : req.data_addr;
        exc_event.bad_vaddr_we = exc_event.taken &&
                                 (exc_event.code == EXC_ADEL ||
                                  exc_event.code == EXC_ADES);
    end

    assign eret_go      = req.valid && req.eret && !exc_event.taken;
    assign flush        = exc_event.taken || eret_go;
    assign flush_target = eret_go ? epc : EXC_VECTOR;

endmodule

`default_nettype wire

//--- logic/cp0_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_regs import cp0_reg_pkg::*, exc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire exc_event_t exc_event,
    input  wire logic       eret_go,
    input  wire logic       mtc0,
    input  wire cp0_addr_t  mtc0_addr,
    input  wire word_t      mtc0_wdata,
    input  wire cp0_addr_t  raddr,
    input  wire word_t      count,
    input  wire word_t      compare,
    input  wire logic       ti,
    output logic            count_we,
    output logic            compare_we,
    output word_t           rdata,
    output cp0_status_t     status,
    output cp0_cause_t      cause,
    output word_t           epc
);

    logic      status_we;
    logic      cause_we;
    logic      epc_we;

    logic      cause_bd;
    logic [6:0] cause_ip_sw;
    exc_code_t cause_exc_code;
    logic [7:0] status_im;
    logic      status_exl;
    logic      status_ie;
    word_t     bad_vaddr;

    // Write decode
    assign status_we  = mtc0 && (mtc0_addr == CP0_STATUS);
    assign cause_we   = mtc0 && (mtc0_addr == CP0_CAUSE);
    assign epc_we     = mtc0 && (mtc0_addr == CP0_EPC);
    assign count_we   = mtc0 && (mtc0_addr == CP0_COUNT);
    assign compare_we = mtc0 && (mtc0_addr == CP0_COMPARE);

    // EPC and BD hold the first fault while EXL is set
    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (epc_we) begin
            epc <= mtc0_wdata;
        end else if (exc_event.taken && !status_exl) begin
            epc <= exc_event.epc_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd <= 1'b0;
        end else if (exc_event.taken && !status_exl) begin
            cause_bd <= exc_event.bd;
        end
    end

    // Software-visible IP bits, IP7 belongs to the timer
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip_sw <= '0;
        end else if (cause_we) begin
            cause_ip_sw <= mtc0_wdata[14:8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_exc_code <= '0;
        end else if (exc_event.taken) begin
            cause_exc_code <= exc_event.code;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im <= '0;
            status_ie <= 1'b0;
        end else if (status_we) begin
            status_im <= mtc0_wdata[15:8];
            status_ie <= mtc0_wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl <= 1'b0;
        end else if (status_we) begin
            status_exl <= mtc0_wdata[1];
        end else if (exc_event.taken) begin
            status_exl <= 1'b1;
        end else if (eret_go) begin
            status_exl <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bad_vaddr <= '0;
        end else if (exc_event.bad_vaddr_we) begin
            bad_vaddr <= exc_event.bad_vaddr;
        end
    end

    always_comb begin
        status     = '0;
        status.bev = 1'b1;
        status.im  = status_im;
        status.exl = status_exl;
        status.ie  = status_ie;
    end

    always_comb begin
        cause          = '0;
        cause.bd       = cause_bd;
        cause.ti       = ti;
        cause.ip       = {ti, cause_ip_sw};
        cause.exc_code = cause_exc_code;
    end

    // mfc0 read, unmapped numbers give zero
    always_comb begin
        case (raddr)
            CP0_BADVADDR: rdata = bad_vaddr;
            CP0_COUNT:    rdata = count;
            CP0_COMPARE:  rdata = compare;
            CP0_STATUS:   rdata = status;
            CP0_CAUSE:    rdata = cause;
            CP0_EPC:      rdata = epc;
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/cp0_top.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_top import cp0_reg_pkg::*, exc_pkg::*; #(
    parameter int    COUNT_DIV  = 2,
    parameter word_t EXC_VECTOR = 32'hbfc00380
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire exc_req_t  req,
    input  wire cp0_addr_t raddr,
    input  wire logic      mtc0,
    input  wire cp0_addr_t mtc0_addr,
    input  wire word_t     mtc0_wdata,
    output word_t          rdata,
    output logic           flush,
    output word_t          flush_target,
    output cp0_status_t    status,
    output cp0_cause_t     cause
);

    exc_event_t exc_event;
    logic       eret_go;
    logic       count_we;
    logic       compare_we;
    logic       ti;
    word_t      count;
    word_t      compare;
    word_t      epc;

    cp0_timer #(
        .COUNT_DIV (COUNT_DIV)
    ) u_cp0_timer (
        .clk        (clk),
        .reset      (reset),
        .count_we   (count_we),
        .compare_we (compare_we),
        .wdata      (mtc0_wdata),
        .count      (count),
        .compare    (compare),
        .ti         (ti)
    );

    exc_unit #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_exc_unit (
        .req          (req),
        .status       (status),
        .cause        (cause),
        .epc          (epc),
        .exc_event    (exc_event),
        .eret_go      (eret_go),
        .flush        (flush),
        .flush_target (flush_target)
    );

    cp0_regs u_cp0_regs (
        .clk        (clk),
        .reset      (reset),
        .exc_event  (exc_event),
        .eret_go    (eret_go),
        .mtc0       (mtc0),
        .mtc0_addr  (mtc0_addr),
        .mtc0_wdata (mtc0_wdata),
        .raddr      (raddr),
        .count      (count),
        .compare    (compare),
        .ti         (ti),
        .count_we   (count_we),
        .compare_we (compare_we),
        .rdata      (rdata),
        .status     (status),
        .cause      (cause),
        .epc        (epc)
    );

endmodule

`default_nettype wire

//--- tb/cp0_chk.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_chk import cp0_reg_pkg::*, exc_pkg::*; (
    input wire logic        clk,
    input wire logic        reset,
    input wire exc_req_t    req,
    input wire logic        flush,
    input wire cp0_status_t status,
    input wire logic        eret_go,
    input wire exc_event_t  exc_event
);

    // No redirect without an instruction at commit
    a_flush_needs_valid: assert property (
        @(posedge clk) disable iff (reset) flush |-> req.valid
    ) else $error("flush raised without a valid commit request");

    // Only bev, im, exl and ie may be nonzero
    a_status_reserved_zero: assert property (
        @(posedge clk) disable iff (reset) (word_t'(status) & 32'hffbf_00fc) == '0
    ) else $error("reserved Status bits are nonzero");

    a_eret_not_with_event: assert property (
        @(posedge clk) disable iff (reset) !(eret_go && exc_event.taken)
    ) else $error("eret_go and a taken event in the same cycle");

endmodule

bind cp0_top cp0_chk u_cp0_chk (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .flush     (flush),
    .status    (status),
    .eret_go   (eret_go),
    .exc_event (exc_event)
);

`default_nettype wire

//--- tb/cp0_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_tb import cp0_reg_pkg::*, exc_pkg::*;;

    localparam int    COUNT_DIV  = 2;
    localparam word_t EXC_VECTOR = 32'hbfc00380;

    logic        clk;
    logic        reset;
    exc_req_t    req;
    cp0_addr_t   raddr;
    logic        mtc0;
    cp0_addr_t   mtc0_addr;
    word_t       mtc0_wdata;
    word_t       rdata;
    logic        flush;
    word_t       flush_target;
    cp0_status_t status;
    cp0_cause_t  cause;

    // Reference model state
    word_t      m_epc;
    word_t      m_bva;
    word_t      m_count;
    word_t      m_compare;
    logic       m_bd;
    logic       m_exl;
    logic       m_ie;
    logic       m_ti;
    logic [6:0] m_ip_sw;
    logic [7:0] m_im;
    exc_code_t  m_code;
    int         m_div;

    integer seed;
    int     total_checks;
    int     total_errors;
    int     test_checks;
    int     test_errors;
    string  test_name;
    logic   last_flush;
    word_t  last_target;
    word_t  last_rdata;

    cp0_top #(
        .COUNT_DIV  (COUNT_DIV),
        .EXC_VECTOR (EXC_VECTOR)
    ) u_cp0_top (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .raddr        (raddr),
        .mtc0         (mtc0),
        .mtc0_addr    (mtc0_addr),
        .mtc0_wdata   (mtc0_wdata),
        .rdata        (rdata),
        .flush        (flush),
        .flush_target (flush_target),
        .status       (status),
        .cause        (cause)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reset_model();
        m_epc     = '0;
        m_bva     = '0;
        m_count   = '0;
        m_compare = '0;
        m_bd      = 1'b0;
        m_exl     = 1'b0;
        m_ie      = 1'b0;
        m_ti      = 1'b0;
        m_ip_sw   = '0;
        m_im      = '0;
        m_code    = '0;
        m_div     = 0;
    endtask

    function automatic word_t status_word();
        return {9'd0, 1'b1, 6'd0, m_im, 6'd0, m_exl, m_ie};
    endfunction

    // IP7 mirrors the timer flag
    function automatic word_t cause_word();
        return {m_bd, m_ti, 14'd0, m_ti, m_ip_sw, 1'b0, m_code, 2'b00};
    endfunction

    function automatic word_t model_read(input cp0_addr_t addr);
        case (addr)
            CP0_BADVADDR: return m_bva;
            CP0_COUNT:    return m_count;
            CP0_COMPARE:  return m_compare;
            CP0_STATUS:   return status_word();
            CP0_CAUSE:    return cause_word();
            CP0_EPC:      return m_epc;
            default:      return '0;
        endcase
    endfunction

    task automatic compare_value(input string what, input word_t expected, input word_t actual);
        total_checks++;
        test_checks++;
        if (expected !== actual) begin
            total_errors++;
            test_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // Check outputs before the edge, then advance the model past it
    task automatic run_cycle();
        logic      int_pend;
        logic      taken;
        logic      eret_go;
        logic      tick;
        exc_code_t code;
        word_t     epc_val;
        #2;
        int_pend = (|({m_ti, m_ip_sw} & m_im)) && m_ie && !m_exl;
        if (int_pend) code = EXC_INT;
        else if (req.adel_if) code = EXC_ADEL;
        else if (req.ri) code = EXC_RI;
        else if (req.ov) code = EXC_OV;
        else if (req.sys) code = EXC_SYS;
        else if (req.bp) code = EXC_BP;
        else if (req.adel) code = EXC_ADEL;
        else code = EXC_ADES;
        taken = req.valid && (int_pend || req.adel_if || req.ri || req.ov || req.sys ||
                              req.bp || req.adel || req.ades);
        eret_go = req.valid && req.eret && !taken;
        epc_val = (req.slot && !req.adel_if) ? req.pc - 32'd4 : req.pc;

        last_flush  = flush;
        last_target = flush_target;
        last_rdata  = rdata;
        compare_value("flush", {31'd0, taken || eret_go}, {31'd0, flush});
        if (taken || eret_go) begin
            compare_value("flush_target", eret_go ? m_epc : EXC_VECTOR, flush_target);
        end
        compare_value($sformatf("rdata[%0d]", raddr), model_read(raddr), rdata);
        compare_value("status", status_word(), status);
        compare_value("cause", cause_word(), cause);

        if (mtc0 && mtc0_addr == CP0_EPC) m_epc = mtc0_wdata;
        else if (taken && !m_exl) m_epc = epc_val;
        if (taken && !m_exl) m_bd = req.slot;
        if (taken && (code == EXC_ADEL || code == EXC_ADES)) begin
            m_bva = req.adel_if ? req.pc : req.data_addr;
        end
        if (taken) m_code = code;
        if (mtc0 && mtc0_addr == CP0_CAUSE) m_ip_sw = mtc0_wdata[14:8];
        if (mtc0 && mtc0_addr == CP0_STATUS) begin
            m_im  = mtc0_wdata[15:8];
            m_ie  = mtc0_wdata[0];
            m_exl = mtc0_wdata[1];
        end else if (taken) begin
            m_exl = 1'b1;
        end else if (eret_go) begin
            m_exl = 1'b0;
        end

        tick = (m_div == COUNT_DIV - 1);
        if (mtc0 && mtc0_addr == CP0_COMPARE) m_ti = 1'b0;
        else if (m_count == m_compare) m_ti = 1'b1;
        if (mtc0 && mtc0_addr == CP0_COUNT) m_count = mtc0_wdata;
        else if (tick) m_count = m_count + 32'd1;
        if (mtc0 && mtc0_addr == CP0_COMPARE) m_compare = mtc0_wdata;
        m_div = tick ? 0 : m_div + 1;
        @(negedge clk);
    endtask

    // Mostly mapped numbers plus two unmapped ones
    function automatic cp0_addr_t rand_addr();
        cp0_addr_t choices [8];
        choices = '{CP0_BADVADDR, CP0_COUNT, CP0_COMPARE, CP0_STATUS,
                    CP0_CAUSE, CP0_EPC, 5'd3, 5'd31};
        return choices[$unsigned($random(seed)) % 8];
    endfunction

    function automatic exc_req_t plain_req(input word_t pc);
        exc_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        return r;
    endfunction

    function automatic exc_req_t random_req();
        exc_req_t r;
        r           = '0;
        r.valid     = ($random(seed) & 7) != 0;
        r.pc        = $random(seed) & 32'hffff_fffc;
        r.slot      = 1'($random(seed));
        r.data_addr = $random(seed);
        r.adel_if   = ($random(seed) & 3) == 0;
        r.ri        = ($random(seed) & 3) == 0;
        r.ov        = ($random(seed) & 3) == 0;
        r.sys       = ($random(seed) & 3) == 0;
        r.bp        = ($random(seed) & 3) == 0;
        r.adel      = ($random(seed) & 3) == 0;
        r.ades      = ($random(seed) & 3) == 0;
        r.eret      = ($random(seed) & 7) == 0;
        return r;
    endfunction

    task automatic idle_cycle();
        req   = '0;
        mtc0  = 1'b0;
        raddr = rand_addr();
        run_cycle();
    endtask

    task automatic write_cp0(input cp0_addr_t addr, input word_t data);
        req        = '0;
        mtc0       = 1'b1;
        mtc0_addr  = addr;
        mtc0_wdata = data;
        raddr      = rand_addr();
        run_cycle();
        mtc0 = 1'b0;
    endtask

    task automatic commit(input exc_req_t r);
        req   = r;
        mtc0  = 1'b0;
        raddr = rand_addr();
        run_cycle();
        req = '0;
    endtask

    task automatic read_reg(input cp0_addr_t addr);
        req   = '0;
        mtc0  = 1'b0;
        raddr = addr;
        run_cycle();
    endtask

    task automatic wait_for_ti(input int limit);
        int n;
        n = 0;
        while (!cause.ti && n < limit) begin
            idle_cycle();
            n++;
        end
        if (!cause.ti) begin
            total_errors++;
            test_errors++;
            $display("ERROR %s: timer interrupt did not rise within %0d cycles",
                     test_name, limit);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d mismatches", test_name, test_checks, test_errors);
    endtask

    initial begin
        seed         = 32'hfe74;
        reset        = 1'b1;
        req          = '0;
        raddr        = '0;
        mtc0         = 1'b0;
        mtc0_addr    = '0;
        mtc0_wdata   = '0;
        total_checks = 0;
        total_errors = 0;
        reset_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test("reset_and_rw");
        read_reg(CP0_CAUSE);
        compare_value("cause after reset", 32'h0, last_rdata);
        read_reg(CP0_COUNT);
        compare_value("count after reset", 32'h0, last_rdata);
        read_reg(CP0_STATUS);
        compare_value("status after reset", 32'h0040_0000, last_rdata);
        for (int a = 0; a < 32; a++) read_reg(cp0_addr_t'(a));
        for (int i = 0; i < 80; i++) begin
            if ($random(seed) & 1) write_cp0(rand_addr(), $random(seed));
            else idle_cycle();
        end
        for (int a = 0; a < 32; a++) read_reg(cp0_addr_t'(a));
        end_test();

        start_test("random_commits");
        for (int i = 0; i < 400; i++) begin
            case ($unsigned($random(seed)) % 8)
                0: write_cp0(CP0_STATUS, {16'd0, 8'($random(seed)), 7'd0, 1'($random(seed))});
                1: idle_cycle();
                default: commit(random_req());
            endcase
        end
        end_test();

        start_test("nested_and_eret");
        write_cp0(CP0_STATUS, 32'h0);
        req      = plain_req(32'h8000_1000);
        req.slot = 1'b1;
        req.ri   = 1'b1;
        commit(req);
        compare_value("ri flush", 32'h1, {31'd0, last_flush});
        compare_value("ri target", EXC_VECTOR, last_target);
        read_reg(CP0_EPC);
        compare_value("epc of slot fault", 32'h8000_0ffc, last_rdata);
        read_reg(CP0_CAUSE);
        compare_value("bd and ri code", 32'h8000_0028, last_rdata & 32'h8000_007c);
        req     = plain_req(32'h8000_2000);
        req.sys = 1'b1;
        commit(req);
        read_reg(CP0_EPC);
        compare_value("epc held under exl", 32'h8000_0ffc, last_rdata);
        read_reg(CP0_CAUSE);
        compare_value("bd held, sys code", 32'h8000_0020, last_rdata & 32'h8000_007c);
        req      = plain_req(32'h8000_3000);
        req.eret = 1'b1;
        commit(req);
        compare_value("eret flush", 32'h1, {31'd0, last_flush});
        compare_value("eret target", 32'h8000_0ffc, last_target);
        read_reg(CP0_STATUS);
        compare_value("exl after eret", 32'h0, last_rdata & 32'h2);
        end_test();

        start_test("timer");
        write_cp0(CP0_COUNT, 32'h100);
        repeat (4 * COUNT_DIV) read_reg(CP0_COUNT);
        write_cp0(CP0_COMPARE, 32'h108);
        read_reg(CP0_CAUSE);
        compare_value("ti after compare write", 32'h0, last_rdata & 32'h4000_0000);
        wait_for_ti(100);
        write_cp0(CP0_COMPARE, 32'h0010_0000);
        read_reg(CP0_CAUSE);
        compare_value("ti cleared", 32'h0, last_rdata & 32'h4000_0000);
        end_test();

        start_test("interrupts");
        write_cp0(CP0_STATUS, 32'h0000_0001);
        write_cp0(CP0_CAUSE, 32'h0000_0100);
        commit(plain_req(32'h8000_4000));
        compare_value("ip0 masked by im", 32'h0, {31'd0, last_flush});
        write_cp0(CP0_STATUS, 32'h0000_0101);
        commit(plain_req(32'h8000_4004));
        compare_value("ip0 taken", 32'h1, {31'd0, last_flush});
        read_reg(CP0_CAUSE);
        compare_value("int code", 32'h0, last_rdata & 32'h0000_007c);
        commit(plain_req(32'h8000_4008));
        compare_value("masked by exl", 32'h0, {31'd0, last_flush});
        write_cp0(CP0_CAUSE, 32'h0);
        write_cp0(CP0_STATUS, 32'h0000_8000);
        write_cp0(CP0_COMPARE, m_count + 32'd6);
        wait_for_ti(100);
        commit(plain_req(32'h8000_5000));
        compare_value("ti masked by ie", 32'h0, {31'd0, last_flush});
        write_cp0(CP0_STATUS, 32'h0000_8001);
        commit(plain_req(32'h8000_5004));
        compare_value("ti taken", 32'h1, {31'd0, last_flush});
        read_reg(CP0_CAUSE);
        compare_value("ti int code", 32'h4000_8000, last_rdata & 32'h4000_807c);
        write_cp0(CP0_COMPARE, 32'hffff_0000);
        write_cp0(CP0_STATUS, 32'h0);
        end_test();

        $display("summary: %0d checks, %0d mismatches", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/cp0_reg_pkg.sv
logic/exc_pkg.sv
logic/cp0_timer.sv
logic/exc_unit.sv
logic/cp0_regs.sv
logic/cp0_top.sv
tb/cp0_chk.sv
tb/cp0_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the CP0 testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cp0_tb -f sim.f -o cp0_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cp0_sim +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
else
    exit 1
fi
